// ==== ic_pkg.sv ====
// AXI4-Lite 2x2 interconnect shared definitions.
// Bus widths, response codes, address map and the decoded target type.
package ic_pkg;

	// bus widths.
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int strb_w = data_w / 8;
	localparam int resp_w = 2;

	// response codes.
	localparam logic [resp_w-1:0] resp_okay   = 2'b00;
	localparam logic [resp_w-1:0] resp_decerr = 2'b11;

	// address map, each slave owns one 4 KB region.
	localparam logic [addr_w-1:0] slave0_base = 32'h0000_0000;
	localparam logic [addr_w-1:0] slave1_base = 32'h0001_0000;
	localparam logic [addr_w-1:0] region_mask = 32'hFFFF_F000;

	// decoded target of a request.
	typedef enum logic [1:0] {
		sel_s0   = 2'd0,
		sel_s1   = 2'd1,
		sel_none = 2'd2
	} sel_t;

endpackage

// ==== axil_req_if.sv ====
// Internal links of the interconnect.
// axil_req_if carries a decoded request, bank_res_if carries the bank result.
interface axil_req_if #(
	parameter int MEM_WORDS = 1024
);
	import ic_pkg::*;

	localparam int idx_w = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	logic              go;
	logic              write;
	sel_t              sel;
	logic [idx_w-1:0]  idx;
	logic [data_w-1:0] wdata;
	logic [strb_w-1:0] wstrb;
	logic              mst;

	modport src (output go, write, sel, idx, wdata, wstrb, mst);
	modport dst (input go, write, sel, idx, wdata, wstrb, mst);

endinterface

interface bank_res_if;
	import ic_pkg::*;

	logic              done;
	logic [data_w-1:0] rdata;
	sel_t              sel;
	logic              write;
	logic              mst;

	modport src (output done, rdata, sel, write, mst);
	modport dst (input done, rdata, sel, write, mst);

endinterface

// ==== ic_addr_decode.sv ====
// Request side of the interconnect.
// Round-robin grant between two masters, address capture and slave decode.
module ic_addr_decode #(
	parameter int MEM_WORDS = 1024
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [ic_pkg::addr_w-1:0] m0_awaddr,
	input  logic                      m0_awvalid,
	output logic                      m0_awready,
	input  logic [ic_pkg::data_w-1:0] m0_wdata,
	input  logic [ic_pkg::strb_w-1:0] m0_wstrb,
	input  logic                      m0_wvalid,
	output logic                      m0_wready,
	input  logic [ic_pkg::addr_w-1:0] m0_araddr,
	input  logic                      m0_arvalid,
	output logic                      m0_arready,
	input  logic [ic_pkg::addr_w-1:0] m1_awaddr,
	input  logic                      m1_awvalid,
	output logic                      m1_awready,
	input  logic [ic_pkg::data_w-1:0] m1_wdata,
	input  logic [ic_pkg::strb_w-1:0] m1_wstrb,
	input  logic                      m1_wvalid,
	output logic                      m1_wready,
	input  logic [ic_pkg::addr_w-1:0] m1_araddr,
	input  logic                      m1_arvalid,
	output logic                      m1_arready,
	axil_req_if.src                   req,
	input  logic                      resp_done
);
	import ic_pkg::*;

	localparam int idx_w = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	typedef enum logic [1:0] {st_idle, st_grant, st_busy} state_t;

	state_t            state;
	logic              last;
	logic              gnt_mst;
	logic              gnt_write;
	logic              want_w0, want_w1;
	logic              pend0, pend1;
	logic              pick;
	logic              pick_write;
	logic [addr_w-1:0] cap_addr;
	logic [addr_w-1:0] word_off;
	logic              in_range;
	sel_t              sel_d;

	// a write needs both AW and W valid on the same master.
	assign want_w0 = m0_awvalid & m0_wvalid;
	assign want_w1 = m1_awvalid & m1_wvalid;
	assign pend0   = want_w0 | m0_arvalid;
	assign pend1   = want_w1 | m1_arvalid;

	// on a tie the master that was not served last wins.
	assign pick       = (pend0 & pend1) ? ~last : pend1;
	assign pick_write = pick ? want_w1 : want_w0;

	assign cap_addr = gnt_write ? (gnt_mst ? m1_awaddr : m0_awaddr)
	                            : (gnt_mst ? m1_araddr : m0_araddr);
	assign word_off = (cap_addr & ~region_mask) >> 2;
	assign in_range = word_off < MEM_WORDS;

	always_comb begin
		if (((cap_addr & region_mask) == slave0_base) && in_range)
			sel_d = sel_s0;
		else if (((cap_addr & region_mask) == slave1_base) && in_range)
			sel_d = sel_s1;
		else
			sel_d = sel_none;
	end

	// ready pulses for one cycle in the grant state.
	assign m0_awready = (state == st_grant) && !gnt_mst && gnt_write;
	assign m0_wready  = (state == st_grant) && !gnt_mst && gnt_write;
	assign m0_arready = (state == st_grant) && !gnt_mst && !gnt_write;
	assign m1_awready = (state == st_grant) && gnt_mst && gnt_write;
	assign m1_wready  = (state == st_grant) && gnt_mst && gnt_write;
	assign m1_arready = (state == st_grant) && gnt_mst && !gnt_write;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state  <= st_idle;
			last   <= 1'b1;
			req.go <= 1'b0;
		end else begin
			req.go <= 1'b0;
			case (state)
				st_idle: begin
					if (pend0 | pend1)
						state <= st_grant;
				end
				st_grant: begin
					state  <= st_busy;
					req.go <= 1'b1;
					last   <= gnt_mst;
				end
				st_busy: begin
					// busy until the response has been taken.
					if (resp_done)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle) begin
			gnt_mst   <= pick;
			gnt_write <= pick_write;
		end
		if (state == st_grant) begin
			req.write <= gnt_write;
			req.sel   <= sel_d;
			req.idx   <= word_off[idx_w-1:0];
			req.wdata <= gnt_mst ? m1_wdata : m0_wdata;
			req.wstrb <= gnt_mst ? m1_wstrb : m0_wstrb;
			req.mst   <= gnt_mst;
		end
	end

endmodule

// ==== ic_sram_bank.sv ====
// The two on-chip SRAM slaves.
// Runs a decoded strobed write or a word read and returns the result a cycle later.
module ic_sram_bank #(
	parameter int MEM_WORDS = 1024
) (
	input  logic    clk,
	input  logic    rst_n,
	axil_req_if.dst req,
	bank_res_if.src res
);
	import ic_pkg::*;

	localparam int idx_w = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	// one array per slave, bank 0 is slave 0.
	logic [data_w-1:0] mem [2][MEM_WORDS];
	logic              bank;
	logic              hit;

	assign bank = (req.sel == sel_s1);
	assign hit  = req.go && (req.sel != sel_none);

	always_ff @(posedge clk) begin
		if (hit && req.write) begin
			for (int b = 0; b < strb_w; b++) begin
				if (req.wstrb[b])
					mem[bank][req.idx][8*b +: 8] <= req.wdata[8*b +: 8];
			end
		end
	end

	// read data, zero for writes and for unmapped addresses.
	always_ff @(posedge clk) begin
		if (req.go) begin
			if (hit && !req.write)
				res.rdata <= mem[bank][req.idx];
			else
				res.rdata <= '0;
			res.sel   <= req.sel;
			res.write <= req.write;
			res.mst   <= req.mst;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			res.done <= 1'b0;
		else
			res.done <= req.go;
	end

endmodule

// ==== ic_resp_route.sv ====
// Response side of the interconnect.
// Builds the B or R response and holds it on the requesting master until taken.
module ic_resp_route (
	input  logic                      clk,
	input  logic                      rst_n,
	bank_res_if.dst                   res,
	output logic [ic_pkg::resp_w-1:0] m0_bresp,
	output logic                      m0_bvalid,
	input  logic                      m0_bready,
	output logic [ic_pkg::data_w-1:0] m0_rdata,
	output logic [ic_pkg::resp_w-1:0] m0_rresp,
	output logic                      m0_rvalid,
	input  logic                      m0_rready,
	output logic [ic_pkg::resp_w-1:0] m1_bresp,
	output logic                      m1_bvalid,
	input  logic                      m1_bready,
	output logic [ic_pkg::data_w-1:0] m1_rdata,
	output logic [ic_pkg::resp_w-1:0] m1_rresp,
	output logic                      m1_rvalid,
	input  logic                      m1_rready,
	output logic                      resp_done
);
	import ic_pkg::*;

	logic [1:0]        bvalid_q;
	logic [1:0]        rvalid_q;
	logic [1:0]        b_hs;
	logic [1:0]        r_hs;
	logic [resp_w-1:0] resp_q;
	logic [data_w-1:0] data_q;

	// bit index is the master number.
	assign b_hs = bvalid_q & {m1_bready, m0_bready};
	assign r_hs = rvalid_q & {m1_rready, m0_rready};

	// only one response is ever pending.
	assign resp_done = |{b_hs, r_hs};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bvalid_q <= '0;
			rvalid_q <= '0;
		end else begin
			bvalid_q <= bvalid_q & ~b_hs;
			rvalid_q <= rvalid_q & ~r_hs;
			if (res.done) begin
				if (res.write)
					bvalid_q[res.mst] <= 1'b1;
				else
					rvalid_q[res.mst] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (res.done) begin
			resp_q <= (res.sel == sel_none) ? resp_decerr : resp_okay;
			data_q <= res.rdata;
		end
	end

	// payload is shared, the valids pick the master.
	assign m0_bvalid = bvalid_q[0];
	assign m1_bvalid = bvalid_q[1];
	assign m0_rvalid = rvalid_q[0];
	assign m1_rvalid = rvalid_q[1];
	assign m0_bresp  = resp_q;
	assign m1_bresp  = resp_q;
	assign m0_rresp  = resp_q;
	assign m1_rresp  = resp_q;
	assign m0_rdata  = data_q;
	assign m1_rdata  = data_q;

endmodule

// ==== axil_ic_2x2.sv ====
// AXI4-Lite interconnect joining two masters to two internal SRAM slaves.
// One transaction in flight, round-robin grant, DECERR outside the map.
module axil_ic_2x2 #(
	parameter int MEM_WORDS = 1024
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [ic_pkg::addr_w-1:0] m0_awaddr,
	input  logic                      m0_awvalid,
	output logic                      m0_awready,
	input  logic [ic_pkg::data_w-1:0] m0_wdata,
	input  logic [ic_pkg::strb_w-1:0] m0_wstrb,
	input  logic                      m0_wvalid,
	output logic                      m0_wready,
	output logic [ic_pkg::resp_w-1:0] m0_bresp,
	output logic                      m0_bvalid,
	input  logic                      m0_bready,
	input  logic [ic_pkg::addr_w-1:0] m0_araddr,
	input  logic                      m0_arvalid,
	output logic                      m0_arready,
	output logic [ic_pkg::data_w-1:0] m0_rdata,
	output logic [ic_pkg::resp_w-1:0] m0_rresp,
	output logic                      m0_rvalid,
	input  logic                      m0_rready,
	input  logic [ic_pkg::addr_w-1:0] m1_awaddr,
	input  logic                      m1_awvalid,
	output logic                      m1_awready,
	input  logic [ic_pkg::data_w-1:0] m1_wdata,
	input  logic [ic_pkg::strb_w-1:0] m1_wstrb,
	input  logic                      m1_wvalid,
	output logic                      m1_wready,
	output logic [ic_pkg::resp_w-1:0] m1_bresp,
	output logic                      m1_bvalid,
	input  logic                      m1_bready,
	input  logic [ic_pkg::addr_w-1:0] m1_araddr,
	input  logic                      m1_arvalid,
	output logic                      m1_arready,
	output logic [ic_pkg::data_w-1:0] m1_rdata,
	output logic [ic_pkg::resp_w-1:0] m1_rresp,
	output logic                      m1_rvalid,
	input  logic                      m1_rready
);

	logic resp_done;

	axil_req_if #(.MEM_WORDS(MEM_WORDS)) req_link ();
	bank_res_if res_link ();

	// decode stage.
	ic_addr_decode #(.MEM_WORDS(MEM_WORDS)) u_addr_decode (
		.clk        (clk),
		.rst_n      (rst_n),
		.m0_awaddr  (m0_awaddr),
		.m0_awvalid (m0_awvalid),
		.m0_awready (m0_awready),
		.m0_wdata   (m0_wdata),
		.m0_wstrb   (m0_wstrb),
		.m0_wvalid  (m0_wvalid),
		.m0_wready  (m0_wready),
		.m0_araddr  (m0_araddr),
		.m0_arvalid (m0_arvalid),
		.m0_arready (m0_arready),
		.m1_awaddr  (m1_awaddr),
		.m1_awvalid (m1_awvalid),
		.m1_awready (m1_awready),
		.m1_wdata   (m1_wdata),
		.m1_wstrb   (m1_wstrb),
		.m1_wvalid  (m1_wvalid),
		.m1_wready  (m1_wready),
		.m1_araddr  (m1_araddr),
		.m1_arvalid (m1_arvalid),
		.m1_arready (m1_arready),
		.req        (req_link.src),
		.resp_done  (resp_done)
	);

	// execute stage.
	ic_sram_bank #(.MEM_WORDS(MEM_WORDS)) u_sram_bank (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req_link.dst),
		.res   (res_link.src)
	);

	// result stage.
	ic_resp_route u_resp_route (
		.clk       (clk),
		.rst_n     (rst_n),
		.res       (res_link.dst),
		.m0_bresp  (m0_bresp),
		.m0_bvalid (m0_bvalid),
		.m0_bready (m0_bready),
		.m0_rdata  (m0_rdata),
		.m0_rresp  (m0_rresp),
		.m0_rvalid (m0_rvalid),
		.m0_rready (m0_rready),
		.m1_bresp  (m1_bresp),
		.m1_bvalid (m1_bvalid),
		.m1_bready (m1_bready),
		.m1_rdata  (m1_rdata),
		.m1_rresp  (m1_rresp),
		.m1_rvalid (m1_rvalid),
		.m1_rready (m1_rready),
		.resp_done (resp_done)
	);

endmodule

// ==== axil_ic_chk.sv ====
// Protocol checker for the AXI4-Lite 2x2 interconnect.
// Response stability, one response at a time, and AW and W taken as a pair.
module axil_ic_chk (
	input logic        clk,
	input logic        rst_n,
	input logic        m0_awvalid, m0_wvalid, m1_awvalid, m1_wvalid,
	input logic        m0_awready, m0_wready, m1_awready, m1_wready,
	input logic        m0_bvalid, m0_bready, m1_bvalid, m1_bready,
	input logic        m0_rvalid, m0_rready, m1_rvalid, m1_rready,
	input logic [1:0]  m0_bresp, m1_bresp, m0_rresp, m1_rresp,
	input logic [31:0] m0_rdata, m1_rdata
);
	timeunit 1ns;
	timeprecision 1ps;

	// a response holds with its payload until taken.
	a_m0_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		m0_bvalid && !m0_bready |=> m0_bvalid && $stable(m0_bresp)) else $error("m0 B dropped");
	a_m1_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		m1_bvalid && !m1_bready |=> m1_bvalid && $stable(m1_bresp)) else $error("m1 B dropped");
	a_m0_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		m0_rvalid && !m0_rready |=> m0_rvalid && $stable({m0_rresp, m0_rdata}))
		else $error("m0 R dropped");
	a_m1_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		m1_rvalid && !m1_rready |=> m1_rvalid && $stable({m1_rresp, m1_rdata}))
		else $error("m1 R dropped");

	a_one_resp: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({m0_bvalid, m0_rvalid, m1_bvalid, m1_rvalid})) else $error("two responses");

	// AW and W are taken together and only while both are valid.
	a_m0_aw_w: assert property (@(posedge clk) disable iff (!rst_n)
		m0_awready == m0_wready && (!m0_awready || (m0_awvalid && m0_wvalid)))
		else $error("m0 awready and wready not paired with AW and W valid");
	a_m1_aw_w: assert property (@(posedge clk) disable iff (!rst_n)
		m1_awready == m1_wready && (!m1_awready || (m1_awvalid && m1_wvalid)))
		else $error("m1 awready and wready not paired with AW and W valid");

endmodule

bind axil_ic_2x2 axil_ic_chk u_chk (.*);

// ==== tb_axil_ic.sv ====
// Testbench for the AXI4-Lite 2x2 interconnect.
// Directed file stimulus, concurrent masters, back-pressure and random traffic
// checked against a reference memory model.
module tb_axil_ic;
	timeunit 1ns;
	timeprecision 1ps;
	import ic_pkg::*;

	localparam int mem_words = 1024;
	localparam int wait_limit = 100;

	logic              clk;
	logic              rst_n;
	logic [addr_w-1:0] awaddr [2];
	logic              awvalid [2];
	logic              awready [2];
	logic [data_w-1:0] wdata [2];
	logic [strb_w-1:0] wstrb [2];
	logic              wvalid [2];
	logic              wready [2];
	logic [resp_w-1:0] bresp [2];
	logic              bvalid [2];
	logic              bready [2];
	logic [addr_w-1:0] araddr [2];
	logic              arvalid [2];
	logic              arready [2];
	logic [data_w-1:0] rdata [2];
	logic [resp_w-1:0] rresp [2];
	logic              rvalid [2];
	logic              rready [2];

	logic [31:0] seed = 32'd21;
	logic [31:0] ref_mem [int];
	int          errors = 0;
	int          test_errors = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;

	axil_ic_2x2 #(.MEM_WORDS(mem_words)) u_axil_ic_2x2 (
		.clk(clk), .rst_n(rst_n),
		.m0_awaddr(awaddr[0]), .m0_awvalid(awvalid[0]), .m0_awready(awready[0]),
		.m0_wdata(wdata[0]), .m0_wstrb(wstrb[0]), .m0_wvalid(wvalid[0]),
		.m0_wready(wready[0]), .m0_bresp(bresp[0]), .m0_bvalid(bvalid[0]),
		.m0_bready(bready[0]), .m0_araddr(araddr[0]), .m0_arvalid(arvalid[0]),
		.m0_arready(arready[0]), .m0_rdata(rdata[0]), .m0_rresp(rresp[0]),
		.m0_rvalid(rvalid[0]), .m0_rready(rready[0]),
		.m1_awaddr(awaddr[1]), .m1_awvalid(awvalid[1]), .m1_awready(awready[1]),
		.m1_wdata(wdata[1]), .m1_wstrb(wstrb[1]), .m1_wvalid(wvalid[1]),
		.m1_wready(wready[1]), .m1_bresp(bresp[1]), .m1_bvalid(bvalid[1]),
		.m1_bready(bready[1]), .m1_araddr(araddr[1]), .m1_arvalid(arvalid[1]),
		.m1_arready(arready[1]), .m1_rdata(rdata[1]), .m1_rresp(rresp[1]),
		.m1_rvalid(rvalid[1]), .m1_rready(rready[1])
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		// the upper state bits come out as the low result bits.
		return {seed[15:0], seed[31:16]};
	endfunction

	// expected response from the two slave byte ranges.
	function automatic logic [resp_w-1:0] map_resp(logic [31:0] a);
		if ((a - slave0_base) < 4 * mem_words || (a - slave1_base) < 4 * mem_words)
			return resp_okay;
		return resp_decerr;
	endfunction

	function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] nw,
	                                            logic [3:0] st);
		logic [31:0] r;
		r = old;
		for (int b = 0; b < 4; b++) begin
			if (st[b])
				r[8*b +: 8] = nw[8*b +: 8];
		end
		return r;
	endfunction

	task automatic check(string name, logic [31:0] exp, logic [31:0] act);
		if (act !== exp) begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic timed_out(string what, int m);
		$display("timeout: master %0d never saw %s", m, what);
		errors++;
	endtask

	// one transaction on master m with the response held back for hold cycles.
	task automatic access(input int m, input bit wr, input logic [31:0] a,
	                      input logic [31:0] wd, input logic [3:0] st, input int hold,
	                      output logic [1:0] resp, output logic [31:0] rd);
		int n;
		bit seen;
		logic [1:0] r0;
		logic [31:0] d0;
		resp = 2'bxx;
		rd = 'x;
		n = 0;
		if (wr) begin
			awaddr[m] = a;
			wdata[m] = wd;
			wstrb[m] = st;
			awvalid[m] = 1'b1;
			wvalid[m] = 1'b1;
			do begin
				@(negedge clk);
				n++;
			end while (!awready[m] && n < wait_limit);
			seen = awready[m];
			if (seen)
				check("wready", 1, wready[m]);
			@(negedge clk);
			awvalid[m] = 1'b0;
			wvalid[m] = 1'b0;
			if (!seen) begin
				timed_out("awready", m);
				return;
			end
			n = 0;
			while (!bvalid[m] && n < wait_limit) begin
				@(negedge clk);
				n++;
			end
			if (!bvalid[m]) begin
				timed_out("bvalid", m);
				return;
			end
			r0 = bresp[m];
			repeat (hold) begin
				@(negedge clk);
				check("bvalid", 1, bvalid[m]);
				check("bresp", r0, bresp[m]);
			end
			bready[m] = 1'b1;
			@(negedge clk);
			bready[m] = 1'b0;
			resp = r0;
			rd = '0;
		end else begin
			araddr[m] = a;
			arvalid[m] = 1'b1;
			do begin
				@(negedge clk);
				n++;
			end while (!arready[m] && n < wait_limit);
			seen = arready[m];
			@(negedge clk);
			arvalid[m] = 1'b0;
			if (!seen) begin
				timed_out("arready", m);
				return;
			end
			n = 0;
			while (!rvalid[m] && n < wait_limit) begin
				@(negedge clk);
				n++;
			end
			if (!rvalid[m]) begin
				timed_out("rvalid", m);
				return;
			end
			r0 = rresp[m];
			d0 = rdata[m];
			repeat (hold) begin
				@(negedge clk);
				check("rvalid", 1, rvalid[m]);
				check("rresp", r0, rresp[m]);
				check("rdata", d0, rdata[m]);
			end
			rready[m] = 1'b1;
			@(negedge clk);
			rready[m] = 1'b0;
			resp = r0;
			rd = d0;
		end
	endtask

	// runs an access and checks it against the reference memory.
	task automatic run_op(int m, bit wr, logic [31:0] a, logic [31:0] wd,
	                      logic [3:0] st, int hold);
		logic [1:0]  er;
		logic [1:0]  resp;
		logic [31:0] rd;
		int          key;
		er = map_resp(a);
		key = int'(a & ~32'h3);
		// bytes never written are unknown, so a first write fills the word.
		if (wr && !ref_mem.exists(key))
			st = 4'hf;
		access(m, wr, a, wd, st, hold, resp, rd);
		check(wr ? "bresp" : "rresp", er, resp);
		if (wr && er == resp_okay)
			ref_mem[key] = merge_bytes(ref_mem.exists(key) ? ref_mem[key] : 0, wd, st);
		if (!wr && er == resp_decerr)
			check("rdata", 0, rd);
		if (!wr && er == resp_okay && ref_mem.exists(key))
			check("rdata", ref_mem[key], rd);
	endtask

	task automatic end_test(string name);
		if (errors == test_errors) begin
			$display("test %s: ok", name);
			tests_passed++;
		end else begin
			$display("test %s: %0d errors", name, errors - test_errors);
			tests_failed++;
		end
		test_errors = errors;
	endtask

	initial begin
		string       line;
		int          fd;
		int          nf;
		int          op;
		int          mi;
		logic [31:0] a;
		logic [31:0] wd;
		logic [31:0] st;
		logic [31:0] er;
		logic [31:0] ed;
		logic [1:0]  resp;
		logic [31:0] rd;
		logic [31:0] a0;
		logic [31:0] a1;
		clk = 1'b0;
		rst_n = 1'b0;
		for (int m = 0; m < 2; m++) begin
			awaddr[m] = '0;
			awvalid[m] = 1'b0;
			wdata[m] = '0;
			wstrb[m] = '0;
			wvalid[m] = 1'b0;
			bready[m] = 1'b0;
			araddr[m] = '0;
			arvalid[m] = 1'b0;
			rready[m] = 1'b0;
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// directed operations with expected values from the stimulus file.
		fd = $fopen("ic_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 3 || line[0] == "#")
					continue;
				nf = $sscanf(line, "%h %h %h %h %h %h %h", op, mi, a, wd, st, er, ed);
				if (nf != 7)
					continue;
				access(mi, op[0], a, wd, st[3:0], 0, resp, rd);
				check(op[0] ? "bresp" : "rresp", er, resp);
				if (!op[0])
					check("rdata", ed, rd);
				if (op[0] && er[1:0] == resp_okay)
					ref_mem[int'(a & ~32'h3)] = merge_bytes(
						ref_mem.exists(int'(a & ~32'h3)) ? ref_mem[int'(a & ~32'h3)] : 0,
						wd, st[3:0]);
			end
			$fclose(fd);
		end
		end_test("directed");

		// both masters at once on distinct words picked by the LCG.
		repeat (8) begin
			a0 = slave0_base + ((lcg_next() % mem_words) << 2);
			a1 = (a0 + 32'h4 + ((lcg_next() % 1000) << 2)) & 32'hFFC;
			a1 = (lcg_next() & 1) ? (slave1_base | a1) : a1;
			wd = lcg_next();
			ed = lcg_next();
			fork
				run_op(0, 1, a0, wd, 4'hf, 0);
				run_op(1, 1, a1, ed, 4'hf, 0);
			join
			fork
				run_op(0, 0, a0, 0, 0, 0);
				run_op(1, 0, a1, 0, 0, 0);
			join
		end
		end_test("concurrent");

		// responses held back by a random number of cycles.
		for (int i = 0; i < 6; i++) begin
			a = slave1_base + ((lcg_next() % mem_words) << 2);
			run_op(i % 2, 1, a, lcg_next(), 4'hf, 1 + lcg_next() % 8);
			run_op((i + 1) % 2, 0, a, 0, 0, 1 + lcg_next() % 8);
		end
		end_test("backpressure");

		// mixed random traffic where a few addresses land outside the map.
		for (int i = 0; i < 200; i++) begin
			a = (lcg_next() % mem_words) << 2;
			op = lcg_next() % 8;
			a = (op == 0) ? (a | 32'h0003_0000) : ((op < 4) ? (a | slave1_base) : a);
			run_op(lcg_next() % 2, lcg_next() % 2, a, lcg_next(), lcg_next() % 16,
			       lcg_next() % 4);
		end
		end_test("random");

		$display("tests passed %0d, failed %0d, errors %0d",
		         tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== ic_stimulus.txt ====
# op(1 write, 0 read) master addr wdata strb exp_resp exp_rdata, all hex
# writes carry 0 as exp_rdata, reads carry 0 as wdata and strb
1 0 00000010 11223344 f 0 0
0 0 00000010 0 0 0 11223344
1 1 00010020 aabbccdd f 0 0
0 1 00010020 0 0 0 aabbccdd
0 0 00010020 0 0 0 aabbccdd
1 1 00000014 cafef00d f 0 0
0 0 00000014 0 0 0 cafef00d
1 0 00000010 000000ee 1 0 0
0 1 00000010 0 0 0 112233ee
1 1 00010020 55660000 c 0 0
0 0 00010020 0 0 0 5566ccdd
1 0 00000014 00abcd00 6 0 0
0 1 00000014 0 0 0 caabcd0d
1 0 00001000 deadbeef f 3 0
0 1 00001000 0 0 3 0
1 1 00020010 12345678 f 3 0
0 0 00020010 0 0 3 0
0 0 00000010 0 0 0 112233ee
0 1 00010020 0 0 0 5566ccdd

// ==== vlog.f ====
ic_pkg.sv
axil_req_if.sv
ic_addr_decode.sv
ic_sram_bank.sv
ic_resp_route.sv
axil_ic_2x2.sv
axil_ic_chk.sv
tb_axil_ic.sv

// ==== Makefile ====
# Verilator build for the AXI4-Lite 2x2 interconnect testbench.
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= tb_axil_ic
RTL_TOP   ?= axil_ic_2x2
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
